// ==== src/fp16_pkg.sv ====
`default_nettype none

package fp16_pkg;

  ////////////////////////////////////////////////////////////
  // FP16 format
  ////////////////////////////////////////////////////////////

  localparam int exp_w = 5;
  localparam int man_w = 10;
  localparam int exp_bias = 15;
  // All-ones exponent marks infinity or NaN
  localparam int exp_max = 31;
  localparam logic [15:0] qnan = 16'h7e00;

  // One word, seen as raw bits or as its fields
  typedef union packed {
    logic [15:0] bits;
    struct packed {
      logic             sign;
      logic [exp_w-1:0] exp;
      logic [man_w-1:0] man;
    } f;
  } fp16_t;

  ////////////////////////////////////////////////////////////
  // Register map, byte offsets
  ////////////////////////////////////////////////////////////

  localparam logic [7:0] reg_ctrl      = 8'h00;
  localparam logic [7:0] reg_status    = 8'h04;
  localparam logic [7:0] reg_scal      = 8'h08;
  localparam logic [7:0] reg_vec1_base = 8'h10;
  localparam logic [7:0] reg_vec2_base = 8'h20;
  localparam logic [7:0] reg_prod_base = 8'h30;
  localparam logic [7:0] reg_sum       = 8'h40;

endpackage

`default_nettype wire

// ==== src/fp16_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp16_mul (
  input  fp16_pkg::fp16_t a,
  input  fp16_pkg::fp16_t b,
  output fp16_pkg::fp16_t y
);

  localparam int sig_w = fp16_pkg::man_w + 1;

  logic                   sign;
  logic [2*sig_w-1:0]     sig_prod;
  logic                   norm;
  logic [fp16_pkg::man_w-1:0] man_out;
  int                     exp_sum;

  assign sign = a.f.sign ^ b.f.sign;

  // Significands with hidden one, 11 x 11 bits
  assign sig_prod = {1'b1, a.f.man} * {1'b1, b.f.man};

  // Product lies in [1,4), so one shift at most
  assign norm = sig_prod[2*sig_w-1];
  assign man_out = norm ? sig_prod[2*fp16_pkg::man_w : fp16_pkg::man_w+1]
                        : sig_prod[2*fp16_pkg::man_w-1 : fp16_pkg::man_w];

  // Biased result exponent, may fall outside 1..30
  assign exp_sum = int'(a.f.exp) + int'(b.f.exp) - fp16_pkg::exp_bias + int'(norm);

  always_comb begin
    if (a.f.exp == fp16_pkg::exp_max || b.f.exp == fp16_pkg::exp_max) begin
      // Inf or NaN operand
      y.bits = fp16_pkg::qnan;
    end else if (a.f.exp == '0 || b.f.exp == '0) begin
      // Zero or flushed subnormal operand
      y.bits = {sign, 15'd0};
    end else if (exp_sum >= fp16_pkg::exp_max) begin
      // Saturate to signed infinity
      y.f.sign = sign;
      y.f.exp  = '1;
      y.f.man  = '0;
    end else if (exp_sum <= 0) begin
      // Result too small, flush
      y.bits = {sign, 15'd0};
    end else begin
      y.f.sign = sign;
      y.f.exp  = exp_sum[fp16_pkg::exp_w-1:0];
      y.f.man  = man_out;
    end
  end

endmodule

`default_nettype wire

// ==== src/fp16_add.sv ====
`timescale 1ns/1ps
`default_nettype none

module fp16_add (
  input  fp16_pkg::fp16_t a,
  input  fp16_pkg::fp16_t b,
  output fp16_pkg::fp16_t y
);

  localparam int sig_w = fp16_pkg::man_w + 1;

  logic            a_zero;
  logic            b_zero;
  fp16_pkg::fp16_t op_hi;
  fp16_pkg::fp16_t op_lo;
  logic [sig_w-1:0] hi_sig;
  logic [sig_w-1:0] lo_sig;
  logic [sig_w:0]   sum_sig;
  logic [sig_w-1:0] norm_sig;
  int               align;
  int               lead;
  int               exp_res;

  // Subnormals count as zero
  assign a_zero = a.f.exp == '0;
  assign b_zero = b.f.exp == '0;

  // Larger magnitude goes to op_hi
  always_comb begin
    if (b_zero || (!a_zero && {a.f.exp, a.f.man} >= {b.f.exp, b.f.man})) begin
      op_hi = a;
      op_lo = b;
    end else begin
      op_hi = b;
      op_lo = a;
    end
  end

  assign align  = int'(op_hi.f.exp) - int'(op_lo.f.exp);
  assign hi_sig = (op_hi.f.exp == '0) ? '0 : {1'b1, op_hi.f.man};
  // Alignment drops the shifted-out bits
  assign lo_sig = ((op_lo.f.exp == '0) ? '0 : {1'b1, op_lo.f.man}) >> align;

  // op_hi is never smaller, so the difference stays positive
  assign sum_sig = (op_hi.f.sign == op_lo.f.sign) ? {1'b0, hi_sig} + {1'b0, lo_sig}
                                                  : {1'b0, hi_sig} - {1'b0, lo_sig};

  ////////////////////////////////////////////////////////////
  // Renormalize
  ////////////////////////////////////////////////////////////

  // Leading-zero count below the carry bit
  always_comb begin
    lead = 0;
    for (int i = 0; i < sig_w; i++) begin
      if (sum_sig[i]) lead = fp16_pkg::man_w - i;
    end
  end

  always_comb begin
    if (sum_sig[sig_w]) begin
      // Carry out, shift right once
      norm_sig = sum_sig[sig_w:1];
      exp_res  = int'(op_hi.f.exp) + 1;
    end else begin
      norm_sig = sum_sig[sig_w-1:0] << lead;
      exp_res  = int'(op_hi.f.exp) - lead;
    end
  end

  always_comb begin
    if (a.f.exp == fp16_pkg::exp_max || b.f.exp == fp16_pkg::exp_max) begin
      // Only inf + inf of one sign survives
      if (a.f.exp == b.f.exp && a.f.man == '0 && b.f.man == '0 && a.f.sign == b.f.sign) begin
        y.f.sign = a.f.sign;
        y.f.exp  = '1;
        y.f.man  = '0;
      end else begin
        y.bits = fp16_pkg::qnan;
      end
    end else if (sum_sig == '0) begin
      // Exact cancellation or two zeros
      y.bits = '0;
    end else if (exp_res >= fp16_pkg::exp_max) begin
      y.f.sign = op_hi.f.sign;
      y.f.exp  = '1;
      y.f.man  = '0;
    end else if (exp_res <= 0) begin
      y.bits = {op_hi.f.sign, 15'd0};
    end else begin
      y.f.sign = op_hi.f.sign;
      y.f.exp  = exp_res[fp16_pkg::exp_w-1:0];
      y.f.man  = norm_sig[fp16_pkg::man_w-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== src/reconf_tile.sv ====
`timescale 1ns/1ps
`default_nettype none

module reconf_tile #(
  parameter int lanes = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  // 1 selects the scalar, 0 selects vec2
  input  logic                   mode,
  input  logic [lanes-1:0][15:0] vec1,
  input  logic [lanes-1:0][15:0] vec2,
  input  logic [15:0]            scal,
  output logic                   out_valid,
  output logic [lanes-1:0][15:0] prod,
  output logic [15:0]            sum
);

  fp16_pkg::fp16_t        mul_b [lanes];
  fp16_pkg::fp16_t        mul_y [lanes];
  // Heap-ordered tree, root at 1, leaves at lanes..2*lanes-1
  fp16_pkg::fp16_t        node [1:2*lanes-1];
  logic [lanes-1:0][15:0] prod_q;
  logic                   valid_q;

  ////////////////////////////////////////////////////////////
  // Lane multipliers
  ////////////////////////////////////////////////////////////

  for (genvar i = 0; i < lanes; i++) begin : g_lane
    assign mul_b[i] = mode ? scal : vec2[i];

    fp16_mul u_mul (
      .a (vec1[i]),
      .b (mul_b[i]),
      .y (mul_y[i])
    );

    // Registered products feed the tree leaves
    assign node[lanes+i] = prod_q[i];
  end

  // Stage one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      for (int i = 0; i < lanes; i++) begin
        prod_q[i] <= mul_y[i];
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Adder tree
  ////////////////////////////////////////////////////////////

  // Node k sums its two children, so neighbours pair first
  for (genvar k = 1; k < lanes; k++) begin : g_tree
    fp16_add u_add (
      .a (node[2*k]),
      .b (node[2*k+1]),
      .y (node[k])
    );
  end

  // Stage two, products delayed to line up with the sum
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= valid_q;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_q) begin
      sum  <= node[1];
      prod <= prod_q;
    end
  end

endmodule

`default_nettype wire

// ==== src/vec_axil_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_axil_regs #(
  parameter int lanes = 4
) (
  input  logic                   clk,
  input  logic                   rst_n,
  // AXI4-Lite slave
  input  logic [7:0]             awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [31:0]            wdata,
  input  logic [3:0]             wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  logic [7:0]             araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  logic                   rready,
  // Tile side
  output logic                   start,
  output logic                   mode,
  output logic [lanes-1:0][15:0] vec1,
  output logic [lanes-1:0][15:0] vec2,
  output logic [15:0]            scal,
  input  logic                   res_valid,
  input  logic [lanes-1:0][15:0] prod,
  input  logic [15:0]            sum
);

  logic                   wr_en;
  logic                   rd_en;
  logic [1:0]             aw_idx;
  logic [1:0]             ar_idx;
  logic [1:0]             inflight;
  logic                   done;
  logic [lanes-1:0][15:0] prod_q;
  logic [15:0]            sum_q;
  logic [31:0]            rd_word;

  // Byte-wise merge under wstrb
  function automatic logic [31:0] apply_strb(logic [31:0] old, logic [31:0] data,
                                             logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = data[8*i +: 8];
    end
    return res;
  endfunction

  // Always OKAY, unmapped addresses included
  assign bresp = 2'b00;
  assign rresp = 2'b00;

  // Master holds valid until ready
  assign wr_en  = awready && awvalid && wvalid;
  assign rd_en  = arready && arvalid;
  // Word within a vector window, two lanes per word
  assign aw_idx = awaddr[3:2];
  assign ar_idx = araddr[3:2];

  ////////////////////////////////////////////////////////////
  // Write channel
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      bvalid  <= 1'b0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      // Address and data together, one write at a time
      if (awvalid && wvalid && !awready && !bvalid) begin
        awready <= 1'b1;
        wready  <= 1'b1;
      end
      if (wr_en) begin
        bvalid <= 1'b1;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Operand registers
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mode  <= 1'b0;
      start <= 1'b0;
      scal  <= '0;
      vec1  <= '0;
      vec2  <= '0;
    end else begin
      // One-cycle pulse on start=1
      start <= wr_en && awaddr[7:2] == fp16_pkg::reg_ctrl[7:2] && wstrb[0] && wdata[1];
      if (wr_en) begin
        if (awaddr[7:2] == fp16_pkg::reg_ctrl[7:2] && wstrb[0]) mode <= wdata[0];
        if (awaddr[7:2] == fp16_pkg::reg_scal[7:2]) begin
          if (wstrb[0]) scal[7:0] <= wdata[7:0];
          if (wstrb[1]) scal[15:8] <= wdata[15:8];
        end
        if (awaddr[7:4] == fp16_pkg::reg_vec1_base[7:4] && int'(aw_idx) < lanes / 2) begin
          vec1[{aw_idx, 1'b0} +: 2] <= apply_strb(vec1[{aw_idx, 1'b0} +: 2], wdata, wstrb);
        end
        if (awaddr[7:4] == fp16_pkg::reg_vec2_base[7:4] && int'(aw_idx) < lanes / 2) begin
          vec2[{aw_idx, 1'b0} +: 2] <= apply_strb(vec2[{aw_idx, 1'b0} +: 2], wdata, wstrb);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Tile tracking and results
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight <= '0;
      done     <= 1'b0;
      prod_q   <= '0;
      sum_q    <= '0;
    end else begin
      case ({start, res_valid})
        2'b10:   inflight <= inflight + 2'd1;
        2'b01:   inflight <= inflight - 2'd1;
        default: inflight <= inflight;
      endcase
      // New result beats the clear on a status read
      if (res_valid) begin
        done   <= 1'b1;
        prod_q <= prod;
        sum_q  <= sum;
      end else if (rd_en && araddr[7:2] == fp16_pkg::reg_status[7:2]) begin
        done <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Read channel
  ////////////////////////////////////////////////////////////

  always_comb begin
    rd_word = '0;
    if (araddr[7:2] == fp16_pkg::reg_ctrl[7:2]) begin
      // Start reads back as 0
      rd_word[0] = mode;
    end else if (araddr[7:2] == fp16_pkg::reg_status[7:2]) begin
      rd_word[1:0] = {done, inflight != 2'd0};
    end else if (araddr[7:2] == fp16_pkg::reg_scal[7:2]) begin
      rd_word[15:0] = scal;
    end else if (araddr[7:2] == fp16_pkg::reg_sum[7:2]) begin
      rd_word[15:0] = sum_q;
    end else if (int'(ar_idx) < lanes / 2) begin
      if (araddr[7:4] == fp16_pkg::reg_vec1_base[7:4]) rd_word = vec1[{ar_idx, 1'b0} +: 2];
      if (araddr[7:4] == fp16_pkg::reg_vec2_base[7:4]) rd_word = vec2[{ar_idx, 1'b0} +: 2];
      if (araddr[7:4] == fp16_pkg::reg_prod_base[7:4]) rd_word = prod_q[{ar_idx, 1'b0} +: 2];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else begin
      arready <= 1'b0;
      if (arvalid && !arready && !rvalid) arready <= 1'b1;
      if (rd_en) begin
        rvalid <= 1'b1;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Read data held until rready
  always_ff @(posedge clk) begin
    if (rd_en) rdata <= rd_word;
  end

endmodule

`default_nettype wire

// ==== src/vec_accel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_accel_top #(
  parameter int lanes = 4
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [7:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [7:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  // Register block to tile
  logic                   start;
  logic                   mode;
  logic [lanes-1:0][15:0] vec1;
  logic [lanes-1:0][15:0] vec2;
  logic [15:0]            scal;
  // Tile back to register block
  logic                   res_valid;
  logic [lanes-1:0][15:0] prod;
  logic [15:0]            sum;

  vec_axil_regs #(
    .lanes (lanes)
  ) u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bresp     (bresp),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rresp     (rresp),
    .rvalid    (rvalid),
    .rready    (rready),
    .start     (start),
    .mode      (mode),
    .vec1      (vec1),
    .vec2      (vec2),
    .scal      (scal),
    .res_valid (res_valid),
    .prod      (prod),
    .sum       (sum)
  );

  reconf_tile #(
    .lanes (lanes)
  ) u_tile (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (start),
    .mode      (mode),
    .vec1      (vec1),
    .vec2      (vec2),
    .scal      (scal),
    .out_valid (res_valid),
    .prod      (prod),
    .sum       (sum)
  );

endmodule

`default_nettype wire

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk
);

  // 10 ns period
  localparam int half_period = 5;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== verif/vec_accel_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_accel_checker (
  input logic       clk,
  input logic       rst_n,
  input logic       bvalid,
  input logic       bready,
  input logic       rvalid,
  input logic       rready,
  input logic       start,
  input logic [1:0] inflight
);

  // Failed assertions so far
  int n_errors = 0;

  ////////////////////////////////////////////////////////////
  // AXI response channels
  ////////////////////////////////////////////////////////////

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      n_errors++;
    end

  a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      n_errors++;
    end

  ////////////////////////////////////////////////////////////
  // Tile issue
  ////////////////////////////////////////////////////////////

  // Start is a single-cycle pulse
  a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    start |=> !start)
    else begin
      $error("start high for two cycles");
      n_errors++;
    end

  a_inflight_max: assert property (@(posedge clk) disable iff (!rst_n)
    inflight <= 2'd2)
    else begin
      $error("more than two items in flight");
      n_errors++;
    end

  // Not busy once reset has been seen
  a_idle_after_reset: assert property (@(posedge clk)
    !rst_n |=> inflight == 2'd0 && !start)
    else begin
      $error("busy right after reset");
      n_errors++;
    end

endmodule

`default_nettype wire

// ==== verif/vec_accel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vec_accel_tb;

  localparam int lanes = 4;
  localparam int words = lanes / 2;
  // Watchdog budget
  localparam int planned_transactions = 600;
  localparam int cycles_per_transaction = 200;
  // Cycles or polls before a handshake counts as lost
  localparam int poll_limit = 50;

  logic                   clk;
  logic                   rst_n;
  logic [7:0]             awaddr;
  logic                   awvalid;
  logic                   awready;
  logic [31:0]            wdata;
  logic [3:0]             wstrb;
  logic                   wvalid;
  logic                   wready;
  logic [1:0]             bresp;
  logic                   bvalid;
  logic                   bready;
  logic [7:0]             araddr;
  logic                   arvalid;
  logic                   arready;
  logic [31:0]            rdata;
  logic [1:0]             rresp;
  logic                   rvalid;
  logic                   rready;

  // Results waiting for the compare process
  string                  name_q[$];
  logic [31:0]            exp_q[$];
  logic [31:0]            act_q[$];

  int                     n_pass;
  int                     n_fail;
  int                     pass_at_start;
  int                     fail_at_start;
  int                     total_fail;
  // Operands for the next start
  logic [lanes-1:0][15:0] op1;
  logic [lanes-1:0][15:0] op2;
  logic [15:0]            op_s;
  logic [31:0]            v;

  tb_clk_gen u_clk (
    .clk (clk)
  );

  vec_accel_top #(
    .lanes (lanes)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  bind vec_axil_regs vec_accel_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .bvalid   (bvalid),
    .bready   (bready),
    .rvalid   (rvalid),
    .rready   (rready),
    .start    (start),
    .inflight (inflight)
  );

  ////////////////////////////////////////////////////////////
  // FP16 reference model
  ////////////////////////////////////////////////////////////

  // Range handling shared by both operations
  function automatic logic [15:0] pack_fp(logic s, int e, int sig);
    if (e >= 31) return {s, 5'h1f, 10'd0};
    if (e <= 0) return {s, 15'd0};
    return {s, e[4:0], sig[9:0]};
  endfunction

  function automatic logic [15:0] ref_mul(logic [15:0] a, logic [15:0] b);
    fp16_pkg::fp16_t x;
    fp16_pkg::fp16_t y;
    logic            s;
    int              p;
    int              e;
    x.bits = a;
    y.bits = b;
    s = x.f.sign ^ y.f.sign;
    if (x.f.exp == 5'h1f || y.f.exp == 5'h1f) return fp16_pkg::qnan;
    // Zero or subnormal operand
    if (x.f.exp == 5'h00 || y.f.exp == 5'h00) return {s, 15'd0};
    p = (1024 + int'(x.f.man)) * (1024 + int'(y.f.man));
    e = int'(x.f.exp) + int'(y.f.exp) - fp16_pkg::exp_bias;
    if (p >= (1 << 21)) begin
      p = p >> 11;
      e = e + 1;
    end else begin
      p = p >> 10;
    end
    return pack_fp(s, e, p);
  endfunction

  function automatic logic [15:0] ref_add(logic [15:0] a, logic [15:0] b);
    fp16_pkg::fp16_t x;
    fp16_pkg::fp16_t y;
    fp16_pkg::fp16_t t;
    int              sx;
    int              sy;
    int              st;
    int              e;
    int              sum;
    x.bits = a;
    y.bits = b;
    if (x.f.exp == 5'h1f || y.f.exp == 5'h1f) begin
      // Equal infinities survive, all else is NaN
      if (a == b && x.f.man == 10'd0) return a;
      return fp16_pkg::qnan;
    end
    sx = (x.f.exp == 5'h00) ? 0 : 1024 + int'(x.f.man);
    sy = (y.f.exp == 5'h00) ? 0 : 1024 + int'(y.f.man);
    // Larger magnitude into x
    if (sy != 0 && (sx == 0 || {y.f.exp, y.f.man} > {x.f.exp, x.f.man})) begin
      t = x;
      x = y;
      y = t;
      st = sx;
      sx = sy;
      sy = st;
    end
    e = int'(x.f.exp);
    sy = sy >> (e - int'(y.f.exp));
    sum = (x.f.sign == y.f.sign) ? sx + sy : sx - sy;
    if (sum == 0) return 16'h0000;
    if (sum >= 2048) begin
      sum = sum >> 1;
      e = e + 1;
    end
    while (sum < 1024) begin
      sum = sum << 1;
      e = e - 1;
    end
    return pack_fp(x.f.sign, e, sum);
  endfunction

  // Lane products, then neighbours pair level by level
  function automatic logic [15:0] ref_tile(input logic m,
                                           input logic [lanes-1:0][15:0] v1,
                                           input logic [lanes-1:0][15:0] v2,
                                           input logic [15:0] s,
                                           output logic [lanes-1:0][15:0] p);
    logic [15:0] lvl [lanes];
    int          n;
    for (int i = 0; i < lanes; i++) begin
      p[i] = ref_mul(v1[i], m ? s : v2[i]);
      lvl[i] = p[i];
    end
    n = lanes;
    while (n > 1) begin
      for (int i = 0; i < n / 2; i++) begin
        lvl[i] = ref_add(lvl[2*i], lvl[2*i+1]);
      end
      n = n / 2;
    end
    return lvl[0];
  endfunction

  // Random operand, exponent kept in 10..20
  function automatic logic [15:0] rand_fp16();
    return {1'($urandom), 5'($urandom_range(20, 10)), 10'($urandom)};
  endfunction

  ////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      n_fail++;
    end else begin
      n_pass++;
    end
  endtask

  task automatic expect_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
    name_q.push_back(name);
    exp_q.push_back(expected);
    act_q.push_back(actual);
  endtask

  // Compare process
  always @(negedge clk) begin
    while (act_q.size() > 0) begin
      check(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
    end
  end

  task automatic start_test();
    pass_at_start = n_pass;
    fail_at_start = n_fail;
  endtask

  task automatic end_test(input string name);
    while (act_q.size() != 0) @(negedge clk);
    $display("%s: %0d checks, %0d failed", name,
             n_pass + n_fail - pass_at_start - fail_at_start, n_fail - fail_at_start);
  endtask

  ////////////////////////////////////////////////////////////
  // AXI4-Lite master
  ////////////////////////////////////////////////////////////

  // Hold keeps bready low that many cycles once bvalid is up
  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold = 0);
    int n;
    @(negedge clk);
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    bready  = 1'b0;
    n = 0;
    while (!(awready && wready) && n < poll_limit) begin
      @(negedge clk);
      n++;
    end
    // Handshake on the edge just after
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (n >= poll_limit) begin
      $display("ERROR: write to 0x%02h was never accepted", addr);
      n_fail++;
    end else if (!bvalid) begin
      $display("ERROR: no write response for 0x%02h", addr);
      n_fail++;
    end else begin
      repeat (hold) @(negedge clk);
      if (!bvalid) begin
        $display("ERROR: write response for 0x%02h lost while stalled", addr);
        n_fail++;
      end
      expect_value("bresp", 32'd0, {30'd0, bresp});
      bready = 1'b1;
      @(negedge clk);
      bready = 1'b0;
    end
  endtask

  // Hold keeps rready low that many cycles once rvalid is up
  task automatic axi_read(input logic [7:0] addr, input int hold,
                          output logic [31:0] data);
    int n;
    @(negedge clk);
    araddr  = addr;
    arvalid = 1'b1;
    rready  = 1'b0;
    n = 0;
    while (!arready && n < poll_limit) begin
      @(negedge clk);
      n++;
    end
    @(negedge clk);
    arvalid = 1'b0;
    data = '0;
    if (n >= poll_limit || !rvalid) begin
      $display("ERROR: read of 0x%02h got no response", addr);
      n_fail++;
    end else begin
      repeat (hold) @(negedge clk);
      if (!rvalid) begin
        $display("ERROR: read data of 0x%02h lost while stalled", addr);
        n_fail++;
      end
      data = rdata;
      expect_value("rresp", 32'd0, {30'd0, rresp});
      rready = 1'b1;
      @(negedge clk);
      rready = 1'b0;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Tile operations
  ////////////////////////////////////////////////////////////

  task automatic load_operands();
    for (int w = 0; w < words; w++) begin
      axi_write(fp16_pkg::reg_vec1_base + 8'(4*w), {op1[2*w+1], op1[2*w]}, 4'hf);
      axi_write(fp16_pkg::reg_vec2_base + 8'(4*w), {op2[2*w+1], op2[2*w]}, 4'hf);
    end
    axi_write(fp16_pkg::reg_scal, {16'h0000, op_s}, 4'hf);
  endtask

  // Poll until done with nothing left in flight
  task automatic wait_done();
    logic [31:0] st;
    int          n;
    n = 0;
    st = '0;
    while (!(st[1] && !st[0]) && n < poll_limit) begin
      axi_read(fp16_pkg::reg_status, 0, st);
      n++;
    end
    if (!(st[1] && !st[0])) begin
      $display("ERROR: done was never reported after a start");
      n_fail++;
    end
  endtask

  task automatic check_results(input logic m, input int hold);
    logic [lanes-1:0][15:0] exp_p;
    logic [15:0]            exp_s;
    logic [31:0]            rd;
    exp_s = ref_tile(m, op1, op2, op_s, exp_p);
    for (int w = 0; w < words; w++) begin
      axi_read(fp16_pkg::reg_prod_base + 8'(4*w), hold, rd);
      expect_value($sformatf("prod_word%0d", w), {exp_p[2*w+1], exp_p[2*w]}, rd);
    end
    axi_read(fp16_pkg::reg_sum, hold, rd);
    expect_value("sum", {16'h0000, exp_s}, rd);
  endtask

  task automatic run_tile(input logic m);
    load_operands();
    axi_write(fp16_pkg::reg_ctrl, {30'd0, 1'b1, m}, 4'h1);
    wait_done();
    check_results(m, 0);
  endtask

  task automatic randomize_operands();
    for (int i = 0; i < lanes; i++) begin
      op1[i] = rand_fp16();
      op2[i] = rand_fp16();
    end
    op_s = rand_fp16();
  endtask

  // Lane 3 first in each literal
  task automatic special_operands(input int k);
    case (k)
      0: begin
        op1 = {16'h0000, 16'h8000, 16'h3c00, 16'h4200};
        op2 = {16'h3c00, 16'h4000, 16'h0000, 16'h8000};
        op_s = 16'h0000;
      end
      1: begin
        op1 = {16'h0400, 16'h83ff, 16'h0001, 16'h3c00};
        op2 = {16'h0400, 16'h3c00, 16'h4000, 16'h0200};
        op_s = 16'h0001;
      end
      2: begin
        op1 = {16'h3c00, 16'h7bff, 16'h7bff, 16'h7800};
        op2 = {16'h3c00, 16'h7bff, 16'h4000, 16'h4000};
        op_s = 16'hfbff;
      end
      3: begin
        op1 = {16'h3c00, 16'h7e00, 16'h4000, 16'h3c00};
        op2 = {16'h3c00, 16'h3c00, 16'h4000, 16'h7c00};
        op_s = 16'h4000;
      end
      default: begin
        op1 = {16'hc000, 16'h4000, 16'hbc00, 16'h3c00};
        op2 = {16'h3c00, 16'h3c00, 16'h3c00, 16'h3c00};
        op_s = 16'h3c00;
      end
    endcase
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(32'h0f49_9190));
    rst_n   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    n_pass  = 0;
    n_fail  = 0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Reset values and register readback
    start_test();
    axi_read(fp16_pkg::reg_status, 0, v);
    expect_value("status", 32'd0, v);
    axi_read(fp16_pkg::reg_sum, 0, v);
    expect_value("sum", 32'd0, v);
    for (int w = 0; w < words; w++) begin
      axi_read(fp16_pkg::reg_prod_base + 8'(4*w), 0, v);
      expect_value("prod", 32'd0, v);
    end
    axi_write(fp16_pkg::reg_vec1_base, 32'h4400_3c00, 4'hf);
    axi_read(fp16_pkg::reg_vec1_base, 0, v);
    expect_value("vec1_word0", 32'h4400_3c00, v);
    axi_write(fp16_pkg::reg_vec1_base + 8'd4, 32'hc000_b800, 4'hf);
    axi_read(fp16_pkg::reg_vec1_base + 8'd4, 0, v);
    expect_value("vec1_word1", 32'hc000_b800, v);
    axi_write(fp16_pkg::reg_vec2_base, 32'h1234_5678, 4'hf);
    axi_write(fp16_pkg::reg_vec2_base, 32'haaaa_bbbb, 4'b1010);
    axi_read(fp16_pkg::reg_vec2_base, 0, v);
    expect_value("vec2_word0", 32'haa34_bb78, v);
    axi_write(fp16_pkg::reg_scal, 32'h0000_ffff, 4'hf);
    axi_write(fp16_pkg::reg_scal, 32'hdead_12ab, 4'b0001);
    axi_read(fp16_pkg::reg_scal, 0, v);
    expect_value("scal", 32'h0000_ffab, v);
    // Mode only, start bit clear
    axi_write(fp16_pkg::reg_ctrl, 32'h0000_0001, 4'hf);
    axi_read(fp16_pkg::reg_ctrl, 0, v);
    expect_value("ctrl", 32'h0000_0001, v);
    axi_read(fp16_pkg::reg_status, 0, v);
    expect_value("status", 32'd0, v);
    axi_write(fp16_pkg::reg_ctrl, 32'h0000_0000, 4'hf);
    // Hole in the map
    axi_write(8'h50, 32'hffff_ffff, 4'hf);
    axi_read(8'h50, 0, v);
    expect_value("unmapped", 32'd0, v);
    end_test("reset and readback");

    start_test();
    repeat (20) begin
      randomize_operands();
      run_tile(1'b0);
    end
    end_test("vector mode");

    start_test();
    repeat (20) begin
      randomize_operands();
      run_tile(1'b1);
    end
    end_test("scalar mode");

    start_test();
    for (int k = 0; k < 5; k++) begin
      special_operands(k);
      run_tile(1'b0);
      run_tile(1'b1);
    end
    end_test("special values");

    // Two starts, the second in scalar mode wins
    start_test();
    randomize_operands();
    load_operands();
    // Write response held back a few cycles
    axi_write(fp16_pkg::reg_ctrl, 32'h0000_0002, 4'h1, 4);
    axi_write(fp16_pkg::reg_ctrl, 32'h0000_0003, 4'h1);
    wait_done();
    check_results(1'b1, 6);
    axi_read(fp16_pkg::reg_status, 0, v);
    expect_value("status", 32'd0, v);
    end_test("back-to-back and back-pressure");

    total_fail = n_fail + DUT.u_regs.u_checker.n_errors;
    $display("checks passed: %0d, failed: %0d", n_pass, total_fail);
    if (total_fail == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (planned_transactions * cycles_per_transaction) @(posedge clk);
    $display("ERROR: simulation did not finish within %0d cycles",
             planned_transactions * cycles_per_transaction);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
src/fp16_pkg.sv
src/fp16_mul.sv
src/fp16_add.sv
src/reconf_tile.sv
src/vec_axil_regs.sv
src/vec_accel_top.sv
verif/tb_clk_gen.sv
verif/vec_accel_checker.sv
verif/vec_accel_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
  --top-module vec_accel_tb -f filelist.f -o vec_accel_sim
./obj_dir/vec_accel_sim +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test OK$" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
